// ==== source/arp_tx_macros.svh ====
`ifndef ARP_TX_MACROS_SVH
`define ARP_TX_MACROS_SVH

// ***************************************************************************
// Ethernet framing
// ***************************************************************************
`define ARP_PREAMBLE_BYTES 7
`define ARP_PREAMBLE_BYTE  8'h55
`define ARP_SFD            8'hD5
`define ARP_ETHERTYPE      16'h0806
`define ARP_PAD_BYTES      18
`define ARP_IFG_BYTES      12

// ***************************************************************************
// ARP header
// ***************************************************************************
`define ARP_HTYPE          16'h0001
`define ARP_PTYPE          16'h0800
`define ARP_HLEN           8'd6
`define ARP_PLEN           8'd4

// Preamble, SFD, 60 covered and 4 FCS bytes, two nibbles each.
`define ARP_FRAME_NIBBLES  144
`define CRC32_POLY         32'hEDB88320

`endif

// ==== source/arp_tx_pkg.sv ====
package arp_tx_pkg;

  // Field of the frame that the sequencer is walking.
  typedef enum logic [4:0]
  {
    idle,
    preamble,
    sfd,
    eth_dst,
    eth_src,
    eth_type,
    htype,
    ptype,
    hlen,
    plen,
    oper,
    sha,
    spa,
    tha,
    tpa,
    pad,
    gap
  } arp_field_e;

  typedef enum logic [15:0]
  {
    op_request = 16'd1,
    op_reply   = 16'd2
  } arp_op_e;

endpackage

// ==== source/arp_frame_sequencer.sv ====
`timescale 1ns/100ps

`include "arp_tx_macros.svh"

module arp_frame_sequencer
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   send,
  input  arp_tx_pkg::arp_op_e    op,
  input  logic [47:0]            src_mac,
  input  logic [31:0]            src_ip,
  input  logic [47:0]            dst_mac,
  input  logic [31:0]            dst_ip,
  output logic [7:0]             seq_byte,
  output logic                   seq_valid,
  output arp_tx_pkg::arp_field_e seq_field,
  output logic                   seq_last,
  output logic                   busy
);

  // Pad slot ends one cycle after its strobe, then twelve idle byte slots.
  localparam logic [4:0] GAP_LAST = 5'(2 * `ARP_IFG_BYTES + 1);

  arp_tx_pkg::arp_field_e field;
  arp_tx_pkg::arp_op_e    op_q;
  logic [47:0]            src_mac_q;
  logic [31:0]            src_ip_q;
  logic [47:0]            dst_mac_q;
  logic [31:0]            dst_ip_q;
  logic [4:0]             cnt;
  logic                   half;
  logic                   accept;
  logic                   emit;
  logic                   is_request;
  logic [7:0]             next_byte;

  // ***************************************************************************
  // Byte selection helpers
  // ***************************************************************************
  function automatic logic [7:0] mac_byte(input logic [47:0] mac, input logic [4:0] idx);
    logic [47:0] shifted;
    shifted = mac << {idx, 3'b000};
    return shifted[47:40];
  endfunction

  function automatic logic [7:0] ip_byte(input logic [31:0] ip, input logic [4:0] idx);
    logic [31:0] shifted;
    shifted = ip << {idx, 3'b000};
    return shifted[31:24];
  endfunction

  function automatic logic [7:0] word_byte(input logic [15:0] w, input logic [4:0] idx);
    return idx[0] ? w[7:0] : w[15:8];
  endfunction

  // Index of the last byte in each field.
  function automatic logic [4:0] field_last(input arp_tx_pkg::arp_field_e f);
    case (f)
      arp_tx_pkg::preamble:
        return 5'(`ARP_PREAMBLE_BYTES - 1);
      arp_tx_pkg::eth_dst, arp_tx_pkg::eth_src, arp_tx_pkg::sha, arp_tx_pkg::tha:
        return 5'(`ARP_HLEN - 1);
      arp_tx_pkg::spa, arp_tx_pkg::tpa:
        return 5'(`ARP_PLEN - 1);
      arp_tx_pkg::eth_type, arp_tx_pkg::htype, arp_tx_pkg::ptype, arp_tx_pkg::oper:
        return 5'd1;
      arp_tx_pkg::pad:
        return 5'(`ARP_PAD_BYTES - 1);
      default:
        return 5'd0;
    endcase
  endfunction

  assign accept     = send & ~busy;
  assign emit       = (field != arp_tx_pkg::idle) && (field != arp_tx_pkg::gap) && !half;
  assign is_request = (op_q == arp_tx_pkg::op_request);

  always_comb
  begin
    case (field)
      arp_tx_pkg::preamble: next_byte = `ARP_PREAMBLE_BYTE;
      arp_tx_pkg::sfd:      next_byte = `ARP_SFD;
      arp_tx_pkg::eth_dst:  next_byte = is_request ? 8'hFF : mac_byte(dst_mac_q, cnt);
      arp_tx_pkg::eth_src:  next_byte = mac_byte(src_mac_q, cnt);
      arp_tx_pkg::eth_type: next_byte = word_byte(`ARP_ETHERTYPE, cnt);
      arp_tx_pkg::htype:    next_byte = word_byte(`ARP_HTYPE, cnt);
      arp_tx_pkg::ptype:    next_byte = word_byte(`ARP_PTYPE, cnt);
      arp_tx_pkg::hlen:     next_byte = `ARP_HLEN;
      arp_tx_pkg::plen:     next_byte = `ARP_PLEN;
      arp_tx_pkg::oper:     next_byte = word_byte(op_q, cnt);
      arp_tx_pkg::sha:      next_byte = mac_byte(src_mac_q, cnt);
      arp_tx_pkg::spa:      next_byte = ip_byte(src_ip_q, cnt);
      arp_tx_pkg::tha:      next_byte = is_request ? 8'h00 : mac_byte(dst_mac_q, cnt);
      arp_tx_pkg::tpa:      next_byte = ip_byte(dst_ip_q, cnt);
      arp_tx_pkg::pad:      next_byte = 8'h00;
      default:              next_byte = 8'h00;
    endcase
  end

  // ***************************************************************************
  // Field walk
  // ***************************************************************************
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      field     <= arp_tx_pkg::idle;
      cnt       <= 5'd0;
      half      <= 1'b0;
      busy      <= 1'b0;
      seq_valid <= 1'b0;
      seq_field <= arp_tx_pkg::idle;
      seq_last  <= 1'b0;
    end
    else
    begin
      seq_valid <= 1'b0;
      seq_last  <= 1'b0;
      case (field)
        arp_tx_pkg::idle:
        begin
          if (accept)
          begin
            field <= arp_tx_pkg::preamble;
            cnt   <= 5'd0;
            half  <= 1'b0; // First byte on the next edge.
            busy  <= 1'b1;
          end
        end
        arp_tx_pkg::gap:
        begin
          if (cnt == GAP_LAST)
          begin
            field <= arp_tx_pkg::idle;
            cnt   <= 5'd0;
            busy  <= 1'b0;
          end
          else
            cnt <= cnt + 5'd1;
        end
        default:
        begin
          half <= ~half;
          if (emit)
          begin
            seq_valid <= 1'b1;
            seq_field <= field;
            seq_last  <= (field == arp_tx_pkg::pad) && (cnt == field_last(field));
            if (cnt == field_last(field))
            begin
              cnt   <= 5'd0;
              field <= arp_tx_pkg::arp_field_e'(field + 5'd1);
            end
            else
              cnt <= cnt + 5'd1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q      <= op;
      src_mac_q <= src_mac;
      src_ip_q  <= src_ip;
      dst_mac_q <= dst_mac;
      dst_ip_q  <= dst_ip;
    end
    if (emit)
      seq_byte <= next_byte;
  end

  // Downstream stages rely on the two-cycle byte cadence.
  a_seq_cadence: assert property (@(posedge clk) disable iff (!arst_n)
    seq_valid |=> !seq_valid);

endmodule

// ==== source/arp_fcs_inserter.sv ====
`timescale 1ns/100ps

`include "arp_tx_macros.svh"

module arp_fcs_inserter
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [7:0]             seq_byte,
  input  logic                   seq_valid,
  input  arp_tx_pkg::arp_field_e seq_field,
  input  logic                   seq_last,
  output logic [7:0]             fcs_byte,
  output logic                   fcs_valid
);

  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

  logic [31:0] crc;
  logic [31:0] fcs_shift;
  logic        covered;
  logic        appending;
  logic [1:0]  app_idx;
  logic        app_half;

  // Reflected CRC-32, one byte, LSB first.
  function automatic logic [31:0] crc32_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++)
    begin
      if (r[0])
        r = (r >> 1) ^ `CRC32_POLY;
      else
        r = r >> 1;
    end
    return r;
  endfunction

  assign covered   = (seq_field != arp_tx_pkg::preamble) && (seq_field != arp_tx_pkg::sfd);
  assign fcs_shift = ~crc >> {app_idx, 3'b000}; // Low byte goes out first.

  // ***************************************************************************
  // CRC and append control
  // ***************************************************************************
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      crc       <= CRC_INIT;
      fcs_valid <= 1'b0;
      appending <= 1'b0;
      app_idx   <= 2'd0;
      app_half  <= 1'b0;
    end
    else
    begin
      fcs_valid <= 1'b0;
      if (seq_valid)
      begin
        fcs_valid <= 1'b1;
        if (covered)
          crc <= crc32_byte(crc, seq_byte);
        if (seq_last)
        begin
          appending <= 1'b1;
          app_idx   <= 2'd0;
          app_half  <= 1'b1; // Keep the two-cycle slot.
        end
      end
      else if (appending)
      begin
        app_half <= ~app_half;
        if (!app_half)
        begin
          fcs_valid <= 1'b1;
          app_idx   <= app_idx + 2'd1;
          if (app_idx == 2'd3)
          begin
            appending <= 1'b0;
            crc       <= CRC_INIT; // Ready for next frame.
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (seq_valid)
      fcs_byte <= seq_byte;
    else if (appending && !app_half)
      fcs_byte <= fcs_shift[7:0];
  end

  // The sequencer must stay quiet until the FCS has been appended.
  a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    appending |-> !seq_valid);

endmodule

// ==== source/mii_nibble_tx.sv ====
`timescale 1ns/100ps

module mii_nibble_tx
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] fcs_byte,
  input  logic       fcs_valid,
  output logic [3:0] txd,
  output logic       tx_en
);

  logic [3:0] hi_q;
  logic       nib_sel;

  // ***************************************************************************
  // Nibble serializer
  // ***************************************************************************
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      txd     <= 4'h0;
      tx_en   <= 1'b0;
      nib_sel <= 1'b0;
    end
    else
    begin
      if (fcs_valid)
      begin
        txd     <= fcs_byte[3:0]; // Low nibble first.
        tx_en   <= 1'b1;
        nib_sel <= 1'b0;
      end
      else if (tx_en && !nib_sel)
      begin
        txd     <= hi_q;
        nib_sel <= 1'b1;
      end
      else
      begin
        txd     <= 4'h0;
        tx_en   <= 1'b0;
        nib_sel <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fcs_valid)
      hi_q <= fcs_byte[7:4];
  end

  // Line idles at zero between frames.
  a_txd_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !tx_en |-> (txd == 4'h0));

endmodule

// ==== source/arp_tx_top.sv ====
`timescale 1ns/100ps

module arp_tx_top
(
  input  logic                clk,
  input  logic                arst_n,
  input  logic                send,
  input  arp_tx_pkg::arp_op_e op,
  input  logic [47:0]         src_mac,
  input  logic [31:0]         src_ip,
  input  logic [47:0]         dst_mac,
  input  logic [31:0]         dst_ip,
  output logic [3:0]          txd,
  output logic                tx_en,
  output logic                busy
);

  logic [7:0]             seq_byte;
  logic                   seq_valid;
  arp_tx_pkg::arp_field_e seq_field;
  logic                   seq_last;
  logic [7:0]             fcs_byte;
  logic                   fcs_valid;

  arp_frame_sequencer u_sequencer
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .send      (send),
    .op        (op),
    .src_mac   (src_mac),
    .src_ip    (src_ip),
    .dst_mac   (dst_mac),
    .dst_ip    (dst_ip),
    .seq_byte  (seq_byte),
    .seq_valid (seq_valid),
    .seq_field (seq_field),
    .seq_last  (seq_last),
    .busy      (busy)
  );

  arp_fcs_inserter u_fcs
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .seq_byte  (seq_byte),
    .seq_valid (seq_valid),
    .seq_field (seq_field),
    .seq_last  (seq_last),
    .fcs_byte  (fcs_byte),
    .fcs_valid (fcs_valid)
  );

  mii_nibble_tx u_mii
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .fcs_byte  (fcs_byte),
    .fcs_valid (fcs_valid),
    .txd       (txd),
    .tx_en     (tx_en)
  );

endmodule

// ==== bench/arp_tx_checks.svh ====
`ifndef ARP_TX_CHECKS_SVH
`define ARP_TX_CHECKS_SVH

// ***************************************************************************
// Reference CRC-32, table form
// ***************************************************************************
function automatic logic [31:0] crc_table_entry(input logic [7:0] idx);
  logic [31:0] e;
  e = {24'h0, idx};
  repeat (8)
    e = e[0] ? ((e >> 1) ^ `CRC32_POLY) : (e >> 1);
  return e;
endfunction

function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] d);
  return crc_table_entry(c[7:0] ^ d) ^ (c >> 8);
endfunction

// ***************************************************************************
// Compare tasks
// ***************************************************************************
task automatic check_nibble(input string what, input int idx, input logic [3:0] got,
                            input logic [3:0] exp);
  if (got !== exp)
    abort_run($sformatf("CHECK FAILED at time %0t: %s %0d is %h, expected %h",
                        $time, what, idx, got, exp));
endtask

task automatic check_op(input arp_tx_pkg::arp_op_e got, input arp_tx_pkg::arp_op_e exp);
  if (got !== exp)
    abort_run($sformatf("CHECK FAILED at time %0t: ARP opcode is %0d, expected %0d",
                        $time, got, exp));
endtask

task automatic check_count(input string what, input int got, input int exp);
  if (got != exp)
    abort_run($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                        $time, what, got, exp));
endtask

task automatic check_level(input string what, input logic got, input logic exp);
  if (got !== exp)
    abort_run($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                        $time, what, got, exp));
endtask

`endif

// ==== bench/arp_tx_tb.sv ====
`timescale 1ns/100ps

`include "arp_tx_macros.svh"

module arp_tx_tb;

  localparam int WAIT_LIMIT = 400; // Cycles per wait.
  localparam int OPER_NIB   = 2 * (`ARP_PREAMBLE_BYTES + 1 + 20);

  logic                clk = 1'b0;
  logic                arst_n;
  logic                send;
  arp_tx_pkg::arp_op_e op;
  logic [47:0]         src_mac;
  logic [31:0]         src_ip;
  logic [47:0]         dst_mac;
  logic [31:0]         dst_ip;
  logic [3:0]          txd;
  logic                tx_en;
  logic                busy;

  int         seed = 32'h40b2;
  int         cycle = 0;
  int         start_cycle;
  int         end_cycle;
  int         frames_started = 0;
  int         frames_done = 0;
  bit         in_frame = 1'b0;
  logic [3:0] cap_nib[$];
  logic [7:0] exp_byte[$];

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "testbench stopped");
  endtask

  `include "arp_tx_checks.svh"

  arp_tx_top u_dut
  (
    .clk     (clk),
    .arst_n  (arst_n),
    .send    (send),
    .op      (op),
    .src_mac (src_mac),
    .src_ip  (src_ip),
    .dst_mac (dst_mac),
    .dst_ip  (dst_ip),
    .txd     (txd),
    .tx_en   (tx_en),
    .busy    (busy)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  // ***************************************************************************
  // Line monitor sampled mid-cycle
  // ***************************************************************************
  always @(negedge clk)
  begin
    if (tx_en)
    begin
      if (!in_frame)
      begin
        cap_nib.delete();
        start_cycle = cycle;
        frames_started++;
        in_frame = 1'b1;
      end
      cap_nib.push_back(txd);
    end
    else
    begin
      check_nibble("idle txd at cycle", cycle, txd, 4'h0);
      if (in_frame)
      begin
        end_cycle = cycle;
        frames_done++;
        in_frame = 1'b0;
      end
    end
  end

  // One cycle of a bounded wait.
  task automatic step_wait(inout int t, input string what);
    @(posedge clk);
    #1;
    t++;
    if (t > WAIT_LIMIT)
      abort_run($sformatf("Timeout after %0d cycles: %s", WAIT_LIMIT, what));
  endtask

  task automatic push_field(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--)
      exp_byte.push_back(v[8 * i +: 8]); // Network order.
  endtask

  task automatic build_expected(input arp_tx_pkg::arp_op_e f_op, input logic [47:0] smac,
                                input logic [31:0] sip, input logic [47:0] dmac,
                                input logic [31:0] dip);
    logic [31:0] crc;
    bit          req;
    req = (f_op == arp_tx_pkg::op_request);
    exp_byte.delete();
    repeat (`ARP_PREAMBLE_BYTES)
      exp_byte.push_back(8'h55);
    exp_byte.push_back(`ARP_SFD);
    push_field(req ? 48'hFFFF_FFFF_FFFF : dmac, 6);
    push_field(smac, 6);
    push_field(48'(`ARP_ETHERTYPE), 2);
    push_field(48'(`ARP_HTYPE), 2);
    push_field(48'(`ARP_PTYPE), 2);
    push_field(48'(`ARP_HLEN), 1);
    push_field(48'(`ARP_PLEN), 1);
    push_field(48'(f_op), 2);
    push_field(smac, 6);
    push_field(48'(sip), 4);
    push_field(req ? 48'h0 : dmac, 6);
    push_field(48'(dip), 4);
    repeat (`ARP_PAD_BYTES)
      exp_byte.push_back(8'h00);
    crc = 32'hFFFF_FFFF;
    for (int i = `ARP_PREAMBLE_BYTES + 1; i < exp_byte.size(); i++)
      crc = crc_update(crc, exp_byte[i]);
    crc = ~crc;
    for (int i = 0; i < 4; i++)
      exp_byte.push_back(crc[8 * i +: 8]); // FCS low byte first.
  endtask

  // ***************************************************************************
  // One frame from send to compare
  // ***************************************************************************
  task automatic run_frame(input arp_tx_pkg::arp_op_e f_op, input logic [47:0] smac,
                           input logic [31:0] sip, input logic [47:0] dmac,
                           input logic [31:0] dip, input int dly, input bit mid);
    int          t;
    int          extra;
    int          accept_edge;
    int          done_before;
    logic [15:0] oper_word;
    t = 0;
    while (busy)
      step_wait(t, "busy did not fall before the next send");
    if (dly > 0)
    begin
      extra = dly + ($random(seed) & 3);
      repeat (extra)
      begin
        @(posedge clk);
        #1;
      end
    end
    build_expected(f_op, smac, sip, dmac, dip);
    op          = f_op;
    src_mac     = smac;
    src_ip      = sip;
    dst_mac     = dmac;
    dst_ip      = dip;
    send        = 1'b1;
    accept_edge = cycle + 1;
    done_before = frames_done;
    @(posedge clk);
    #1;
    send = 1'b0;
    check_level("busy after the accepted send", busy, 1'b1);
    t = 0;
    while (frames_started == done_before)
      step_wait(t, "tx_en never rose after an accepted send");
    check_count("cycles from accepted send to tx_en", start_cycle - accept_edge, 3);
    if (mid)
    begin
      repeat (20)
      begin
        @(posedge clk);
        #1;
      end
      op      = req_flip(f_op);
      src_mac = ~smac;
      src_ip  = ~sip;
      dst_mac = ~dmac;
      dst_ip  = ~dip;
      send    = 1'b1;
      @(posedge clk);
      #1;
      send = 1'b0;
      check_level("busy after a send during a frame", busy, 1'b1);
    end
    t = 0;
    while (frames_done == done_before)
      step_wait(t, "tx_en never fell at the end of the frame");
    check_count("tx_en high cycles", end_cycle - start_cycle, `ARP_FRAME_NIBBLES);
    oper_word = {cap_nib[OPER_NIB + 1], cap_nib[OPER_NIB],
                 cap_nib[OPER_NIB + 3], cap_nib[OPER_NIB + 2]};
    check_op(arp_tx_pkg::arp_op_e'(oper_word), f_op);
    for (int i = 0; i < cap_nib.size(); i++)
      check_nibble("frame nibble", i, cap_nib[i],
                   (i % 2 != 0) ? exp_byte[i / 2][7:4] : exp_byte[i / 2][3:0]);
    t = 0;
    while (busy)
      step_wait(t, "busy never fell after the frame");
    check_count("cycles from tx_en low to busy low", cycle - end_cycle, 14);
    check_count("cycles from accepted send to busy low", cycle - accept_edge,
                1 + 2 * (`ARP_PREAMBLE_BYTES + 1 + 60) + 2 * `ARP_IFG_BYTES);
    check_level("tx_en once busy is low", tx_en, 1'b0);
  endtask

  function automatic arp_tx_pkg::arp_op_e req_flip(input arp_tx_pkg::arp_op_e o);
    return (o == arp_tx_pkg::op_request) ? arp_tx_pkg::op_reply : arp_tx_pkg::op_request;
  endfunction

  initial
  begin
    string       line;
    int          fd;
    int          n;
    int          dly;
    int          mid;
    int          frame_cnt;
    logic [15:0] op_word;
    logic [47:0] smac;
    logic [47:0] dmac;
    logic [31:0] sip;
    logic [31:0] dip;
    arst_n    = 1'b0;
    send      = 1'b0;
    op        = arp_tx_pkg::op_request;
    src_mac   = '0;
    src_ip    = '0;
    dst_mac   = '0;
    dst_ip    = '0;
    frame_cnt = 0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_level("tx_en after reset", tx_en, 1'b0);
    check_level("busy after reset", busy, 1'b0);
    fd = $fopen("bench/arp_tx_input.txt", "r");
    if (fd == 0)
      abort_run("Cannot open the stimulus file bench/arp_tx_input.txt");
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() > 1 && line.substr(0, 0) != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h %d %d", op_word, smac, sip, dmac, dip, dly, mid);
        if (n != 7)
          abort_run({"Malformed stimulus line: ", line});
        run_frame(arp_tx_pkg::arp_op_e'(op_word), smac, sip, dmac, dip, dly, mid != 0);
        frame_cnt++;
      end
    end
    $fclose(fd);
    repeat (50) // Quiet line with no stray frame.
    begin
      @(posedge clk);
      #1;
    end
    check_count("frames seen on the line", frames_started, frame_cnt);
    check_level("busy at the end", busy, 1'b0);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+source
+incdir+bench
source/arp_tx_pkg.sv
source/arp_frame_sequencer.sv
source/arp_fcs_inserter.sv
source/mii_nibble_tx.sv
source/arp_tx_top.sv
bench/arp_tx_tb.sv

// ==== Makefile ====
# Verilator build and run of the ARP transmitter testbench.
VERILATOR ?= verilator
TOP       ?= arp_tx_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(FILELIST) source/arp_tx_macros.svh source/arp_tx_pkg.sv \
           source/arp_frame_sequencer.sv source/arp_fcs_inserter.sv \
           source/mii_nibble_tx.sv source/arp_tx_top.sv \
           bench/arp_tx_checks.svh bench/arp_tx_tb.sv

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/arp_tx_input.txt ====
# op src_mac src_ip dst_mac dst_ip (hex), idle_delay mid_frame_send (decimal)
# op 1 is a request, 2 a reply; delay 0 sends on the first cycle that busy is low
1 02005e10aa01 c0a80001 00163e5f2b7c c0a80002 3 0
2 02005e10aa01 c0a80001 00163e5f2b7c c0a80002 0 0
1 a4bb6d0f1122 0a000a05 000000000000 0a000a01 5 1
2 a4bb6d0f1122 0a000a05 f0debc9a7856 0a000a01 0 1
2 ffeeddccbbaa 7f000001 112233445566 7f0000fe 2 0
1 3c22fb9e0d41 ac100101 9a8b7c6d5e4f ac1001ff 0 0
2 3c22fb9e0d41 ac100101 00000000001b ac100114 7 1
1 000000000001 c0a8fe01 ffffffffffff c0a8fe02 1 0
2 5254001234ab 0a0a0a0a 5254005678cd 0a0a0a0b 0 1
1 5254005678cd 0a0a0a0b 5254001234ab 0a0a0a0a 4 1
